// ==== list.f ====
logic/isa_pkg.sv
logic/core_pkg.sv
logic/rv_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/cpu_top.sv
sim/tb_cpu.sv

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
  import core_pkg::*;
(
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t rdata_1,
  input  word_t rdata_2,
  output word_t result
);

  word_t operand_a;
  word_t operand_b;

  // ==============================
  // operand select
  // ==============================
  assign operand_a = ctrl.use_pc  ? pc       : rdata_1;  // auipc takes pc
  assign operand_b = ctrl.use_imm ? ctrl.imm : rdata_2;  // i / u forms

  // plain 32 bit wraparound, no flags
  always_comb begin
    case (ctrl.alu_op)
      alu_add:    result = operand_a + operand_b;
      alu_sub:    result = operand_a - operand_b;
      alu_pass_b: result = operand_b;     // lui
      default:    result = operand_b;     // unused encoding
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;
  import isa_pkg::*;

  typedef logic [xlen-1:0] word_t;        // datapath word

  // alu function select
  typedef enum logic [1:0] {
    alu_add    = 2'd0,
    alu_sub    = 2'd1,
    alu_pass_b = 2'd2                     // lui just forwards the immediate
  } alu_op_t;

  // ==============================
  // decoded control, decode -> execute
  // ==============================
  typedef struct packed {
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    word_t   imm;                         // already extended / shifted
    alu_op_t alu_op;
    logic    use_imm;                     // operand b from imm
    logic    use_pc;                      // operand a from pc, auipc
    logic    reg_wen;
    logic    is_ebreak;
    logic    illegal;
  } ctrl_t;

  // retired instruction, also the regfile write port
  typedef struct packed {
    logic    wen;
    reg_id_t rd;
    word_t   data;
    word_t   pc;                          // address of the committing inst
  } commit_t;

  localparam word_t reset_pc = '0;

endpackage

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import isa_pkg::*, core_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  word_t   inst,                   // from external imem, same cycle
  output word_t   pc,
  output commit_t commit,
  output logic    halted,
  output logic    illegal
);

  inst_u inst_w;                          // fetched word seen as formats
  ctrl_t ctrl;
  word_t rdata_1;
  word_t rdata_2;
  word_t alu_result;

  assign inst_w = inst;

  // ==============================
  // decode
  // ==============================
  rv_decoder u_decoder (
    .inst (inst_w),
    .ctrl (ctrl)
  );

  assign illegal = ctrl.illegal;          // flagged only, inst retires as nop

  // ==============================
  // execute
  // ==============================
  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .wr      (commit),                    // write back at next rising edge
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  alu u_alu (
    .ctrl    (ctrl),
    .pc      (pc),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .result  (alu_result)
  );

  // ==============================
  // result, write back and next pc
  // ==============================
  always_comb begin
    commit.wen  = ctrl.reg_wen & ~halted & rst_n; // no writes once stopped
    commit.rd   = ctrl.rd;
    commit.data = alu_result;
    commit.pc   = pc;
  end

  pc_unit u_pc_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .ebreak (ctrl.is_ebreak),
    .pc     (pc),
    .halted (halted)
  );

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // ==============================
  // base widths
  // ==============================
  localparam int xlen = 32;               // one word, data and address

  typedef logic [4:0] reg_id_t;           // x0 .. x31

  // ==============================
  // major opcodes kept by the core
  // ==============================
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,               // addi
    op_reg    = 7'b0110011,               // add, sub
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_system = 7'b1110011                // only ebreak handled
  } opcode_t;

  localparam logic [2:0]      funct3_add  = 3'b000;
  localparam logic [6:0]      funct7_base = 7'b0000000;
  localparam logic [6:0]      funct7_sub  = 7'b0100000;
  localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

  // ==============================
  // instruction formats, msb first
  // ==============================
  typedef struct packed {
    logic [6:0] funct7;
    reg_id_t    rs2;
    reg_id_t    rs1;
    logic [2:0] funct3;
    reg_id_t    rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;                     // sign bit at 11
    reg_id_t     rs1;
    logic [2:0]  funct3;
    reg_id_t     rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;                     // upper 20 bits of the word
    reg_id_t     rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one fetched word, several readings of it
  typedef union packed {
    r_fmt_t          r;
    i_fmt_t          i;
    u_fmt_t          u;
    logic [xlen-1:0] raw;
  } inst_u;

endpackage

`default_nettype wire

// ==== logic/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ebreak,                   // current inst is ebreak
  output word_t pc,
  output logic  halted
);

  localparam word_t inst_bytes = word_t'(4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else if (!halted) begin
      if (ebreak) begin
        halted <= 1'b1;                   // pc stays on the ebreak
      end else begin
        pc <= pc + inst_bytes;            // no branches, always sequential
      end
    end
    // halted, everything frozen until reset
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import isa_pkg::*, core_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  reg_id_t rs1,
  input  reg_id_t rs2,
  input  commit_t wr,                     // write port, taken from commit
  output word_t   rdata_1,
  output word_t   rdata_2
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.wen && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;             // writes to x0 dropped
    end
  end

  // asynchronous read, x0 hard zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
  import isa_pkg::*, core_pkg::*;
(
  input  inst_u inst,
  output ctrl_t ctrl
);

  opcode_t opcode;

  // opcode sits in the same bits for every format
  assign opcode = opcode_t'(inst.raw[6:0]);

  always_comb begin
    // register ids sit in the same bits in every format
    ctrl           = '0;
    ctrl.rd        = inst.r.rd;
    ctrl.rs1       = inst.r.rs1;
    ctrl.rs2       = inst.r.rs2;
    ctrl.alu_op    = alu_add;

    case (opcode)
      // ==============================
      // i-type addi
      // ==============================
      op_imm: begin
        if (inst.i.funct3 == funct3_add) begin
          ctrl.imm     = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm}; // sign extend
          ctrl.use_imm = 1'b1;
          ctrl.reg_wen = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;            // other alu-imm ops not built
        end
      end

      // r-type add / sub
      op_reg: begin
        if (inst.r.funct3 == funct3_add && inst.r.funct7 == funct7_base) begin
          ctrl.reg_wen = 1'b1;
        end else if (inst.r.funct3 == funct3_add && inst.r.funct7 == funct7_sub) begin
          ctrl.alu_op  = alu_sub;
          ctrl.reg_wen = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end

      // ==============================
      // u-type
      // ==============================
      op_lui: begin
        ctrl.imm     = {inst.u.imm, 12'b0};
        ctrl.alu_op  = alu_pass_b;        // result is the immediate itself
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
      end

      op_auipc: begin
        ctrl.imm     = {inst.u.imm, 12'b0};
        ctrl.use_pc  = 1'b1;              // pc + upper imm
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
      end

      op_system: begin
        if (inst.raw == ebreak_word) ctrl.is_ebreak = 1'b1;
        else                         ctrl.illegal   = 1'b1; // ecall and csr ops
      end

      default: begin
        ctrl.illegal = 1'b1;              // unknown opcode runs as a nop
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the cpu testbench with verilator, run it, judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_cpu -f list.f \
  -o tb_cpu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log
grep -qF "=== FAIL ===" sim.log && exit 1
grep -qF "=== PASS ===" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
  import isa_pkg::*, core_pkg::*;
();

  localparam int clk_period  = 40;
  localparam int n_imm       = 80;
  localparam int n_reg       = 120;
  localparam int n_illegal   = 30;
  localparam int n_halt      = 10;
  // reset, the five tests, plus slack
  localparam int cycle_limit = 3 + n_imm + n_reg + n_illegal + (n_halt + 4) + 40;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  logic    clk;
  logic    rst_n;
  word_t   inst;                          // the testbench is the imem
  word_t   pc;
  commit_t commit;
  logic    halted;
  logic    illegal;

  word_t       model_regs [0:31];         // entry 0 never written
  word_t       model_pc;
  logic        model_halted;
  logic [31:0] lfsr_state;
  int          error_count;
  int          check_count;
  int          test_count;
  int          test_err_start;
  int          cycle_count;
  string       test_name;

  cpu_top uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .commit  (commit),
    .halted  (halted),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ==============================
  // random instruction source
  // ==============================
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? lfsr_taps : 32'h0);
      v = {v[30:0], lfsr_state[0]};       // one step per bit taken
    end
    return v;
  endfunction

  function automatic word_t rand_imm_inst();
    inst_u      w;
    logic [1:0] kind;
    kind = 2'(next_bits(2));
    if (kind[1] == 1'b0) begin            // addi on half the draws
      w.i = '{imm: 12'(next_bits(12)), rs1: reg_id_t'(next_bits(5)), funct3: funct3_add,
              rd: reg_id_t'(next_bits(5)), opcode: op_imm};
    end else begin
      w.u = '{imm: 20'(next_bits(20)), rd: reg_id_t'(next_bits(5)),
              opcode: (kind[0] ? op_auipc : op_lui)};
    end
    return w.raw;
  endfunction

  // x0..x7 only so x0 shows up often as source and target
  function automatic word_t rand_reg_inst();
    inst_u w;
    w.r = '{funct7: (next_bits(1) == 32'd1 ? funct7_sub : funct7_base),
            rs2: reg_id_t'(next_bits(3)), rs1: reg_id_t'(next_bits(3)),
            funct3: funct3_add, rd: reg_id_t'(next_bits(3)), opcode: op_reg};
    return w.raw;
  endfunction

  function automatic logic known_opcode(input logic [6:0] op);
    return op inside {op_imm, op_reg, op_lui, op_auipc, op_system};
  endfunction

  function automatic word_t rand_illegal_word();
    word_t w;
    w = next_bits(32);
    while (known_opcode(w[6:0])) begin
      w = next_bits(32);                  // redraw until the opcode is unknown
    end
    return w;
  endfunction

  // ==============================
  // reference model from the isa rules
  // ==============================
  function automatic logic legal_inst(input inst_u ins);
    case (ins.raw[6:0])
      op_imm:           return ins.raw[14:12] == 3'b000;
      op_reg:           return ins.raw[14:12] == 3'b000 &&
                               (ins.raw[31:25] == 7'h00 || ins.raw[31:25] == 7'h20);
      op_lui, op_auipc: return 1'b1;
      op_system:        return ins.raw == ebreak_word;
      default:          return 1'b0;
    endcase
  endfunction

  function automatic commit_t expect_commit(input inst_u ins, input word_t cur_pc,
                                            input logic is_halted);
    commit_t c;
    word_t   a;
    word_t   b;
    word_t   imm_i;
    word_t   imm_u;
    a     = model_regs[ins.raw[19:15]];   // x0 entry stays zero
    b     = model_regs[ins.raw[24:20]];
    imm_i = {{20{ins.raw[31]}}, ins.raw[31:20]};
    imm_u = {ins.raw[31:12], 12'h000};
    c     = '0;
    c.pc  = cur_pc;
    c.rd  = ins.raw[11:7];
    if (legal_inst(ins) && !is_halted) begin
      case (ins.raw[6:0])
        op_imm:   c.data = a + imm_i;
        op_reg:   c.data = ins.raw[30] ? a - b : a + b;  // bit 30 splits sub from add
        op_lui:   c.data = imm_u;
        op_auipc: c.data = cur_pc + imm_u;
        default:  c.data = '0;            // ebreak writes nothing
      endcase
      c.wen = (ins.raw[6:0] != op_system);
    end
    return c;
  endfunction

  // ==============================
  // compare tasks
  // ==============================
  task automatic check_commit(input commit_t got, input commit_t exp);
    check_count++;
    // rd and data only matter when a write is expected
    if (got.wen !== exp.wen || got.pc !== exp.pc ||
        (exp.wen && (got.rd !== exp.rd || got.data !== exp.data))) begin
      error_count++;
      $display("** Error at %0t: commit wen/rd/data/pc %0b/%0d/%h/%h, expected %0b/%0d/%h/%h",
               $time, got.wen, got.rd, got.data, got.pc, exp.wen, exp.rd, exp.data, exp.pc);
    end
  endtask

  task automatic check_pc(input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: pc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // outputs settle after the falling edge drive and state moves after this edge
  always @(posedge clk) begin : compare
    commit_t expected;
    if (!rst_n) begin
      model_pc     = reset_pc;
      model_halted = 1'b0;
      check_pc(pc, reset_pc);
      check_flag(commit.wen, 1'b0, "commit.wen in reset");
      check_flag(halted, 1'b0, "halted in reset");
    end else begin
      expected = expect_commit(inst, model_pc, model_halted);
      check_pc(pc, model_pc);
      check_commit(commit, expected);
      check_flag(halted, model_halted, "halted");
      check_flag(illegal, !legal_inst(inst), "illegal");
      if (expected.wen && expected.rd != '0) begin
        model_regs[expected.rd] = expected.data;
      end
      if (!model_halted) begin
        if (inst == ebreak_word) model_halted = 1'b1;  // pc stays on the ebreak
        else                     model_pc     = model_pc + 32'd4;
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("simulation timed out after %0d cycles", cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

  // ==============================
  // test sequencing
  // ==============================
  task automatic drive(input word_t w);
    @(negedge clk);
    inst = w;
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = error_count;
  endtask

  task automatic finish_test();
    @(posedge clk);                       // last word of the test is checked here
    #1;
    test_count++;
    if (error_count == test_err_start) $display("test %s: passed", test_name);
    else $display("test %s: failed, %0d errors", test_name, error_count - test_err_start);
  endtask

  initial begin : stimulus
    rst_n        = 1'b0;
    inst         = 32'h0050_0093;         // addi x1, x0, 5 held in reset must not write
    lfsr_state   = 32'd73522;
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    model_pc     = reset_pc;
    model_halted = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end

    begin_test("reset");
    repeat (2) @(posedge clk);            // two full cycles with rst_n low
    @(negedge clk);
    rst_n = 1'b1;
    inst  = '0;                           // first fetch at pc 0 is an illegal word
    finish_test();

    begin_test("imm_upper");
    repeat (n_imm) drive(rand_imm_inst());
    finish_test();

    begin_test("reg_ops");
    repeat (n_reg) drive(rand_reg_inst());
    finish_test();

    begin_test("illegal");
    repeat (n_illegal) drive(rand_illegal_word());
    finish_test();

    begin_test("halt");
    drive(rand_imm_inst());
    drive(ebreak_word);
    repeat (n_halt) drive(ebreak_word);   // frozen pc fetches the same word
    repeat (2) drive(rand_imm_inst());    // imem changed under a stopped core
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
